//--- cpu_core.f
+incdir+source
source/cpu_pkg.sv
source/cpu_alu.sv
source/cpu_decode.sv
source/cpu_control.sv
source/cpu_datapath.sv
source/cpu_core.sv
verif/cpu_core_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module cpu_core_tb -Mdir obj_dir -f cpu_core.f \
    && ./obj_dir/Vcpu_core_tb | tee /dev/stderr | grep "Simulation completed successfully" > /dev/null \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

//--- verif/cpu_core_tb.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu_core_tb;

    localparam int timeout_cycles = 1000;

    // 6502 encodings used to build the test programs
    localparam logic [7:0] op_clc = 8'h18;
    localparam logic [7:0] op_sec = 8'h38;
    localparam logic [7:0] op_lda = 8'hA9;
    localparam logic [7:0] op_bcs = 8'hB0;
    localparam logic [7:0] op_bcc = 8'h90;

    logic        i_clock;
    logic        i_rst_n;
    logic        i_clock_en;
    logic [7:0]  i_r_data = 8'h00;
    logic [15:0] o_addr;
    logic        o_mem_r_en;
    logic [15:0] o_pc;
    logic [7:0]  o_a;
    logic [7:0]  o_x;
    logic [7:0]  o_y;
    logic [3:0]  o_flags;

    logic [7:0]  mem [0:65535];
    logic [15:0] load_ptr;
    // address of the last self branch written
    logic [15:0] end_addr;
    int          errors = 0;
    int          timeouts = 0;
    int          seed = 32'h6271;

    // arithmetic operands that the stall test replays
    logic [7:0]  seq_a [20];
    logic [7:0]  seq_m [20];
    logic        seq_c [20];
    int          seq_op [20];

    cpu_core u_cpu_core (
        .i_clock    (i_clock),
        .i_rst_n    (i_rst_n),
        .i_clock_en (i_clock_en),
        .i_r_data   (i_r_data),
        .o_addr     (o_addr),
        .o_mem_r_en (o_mem_r_en),
        .o_pc       (o_pc),
        .o_a        (o_a),
        .o_x        (o_x),
        .o_y        (o_y),
        .o_flags    (o_flags)
    );

    initial begin
        i_clock = 1'b0;
        forever #2 i_clock = ~i_clock;
    end

    // registered read with the byte valid one cycle after the strobe
    always @(posedge i_clock) begin
        if (o_mem_r_en) begin
            i_r_data <= mem[o_addr];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // program building

    task automatic fill_memory();
        logic [15:0] addr;
        int k;
        for (k = 0; k < 65536; k++) begin
            addr = k[15:0];
            mem[addr] = addr[15:8] ^ addr[7:0] ^ 8'h5A;
        end
    endtask

    task automatic emit(input logic [7:0] b);
        mem[load_ptr] = b;
        load_ptr = load_ptr + 16'h0001;
    endtask

    // CLC then BCC to itself
    task automatic emit_end();
        emit(op_clc);
        end_addr = load_ptr;
        emit(op_bcc);
        emit(8'hFE);
    endtask

    // right aligned bytes with the first one most significant
    task automatic load_code(input logic [127:0] code, input int count);
        int k;
        load_ptr = `CPU_RESET_PC;
        for (k = count - 1; k >= 0; k--) begin
            emit(code[k*8 +: 8]);
        end
        emit_end();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // running and checking

    task automatic apply_reset();
        @(posedge i_clock);
        i_rst_n <= 1'b0;
        i_clock_en <= 1'b1;
        repeat (5) @(posedge i_clock);
        i_rst_n <= 1'b1;
    endtask

    task automatic run_to_loop(input bit stall);
        int cycles;
        int strobes;
        int stall_left;
        logic [15:0] prev1;
        logic [15:0] prev2;
        bit looped;
        cycles = 0;
        strobes = 0;
        stall_left = 0;
        prev1 = 16'h0000;
        prev2 = 16'h0000;
        looped = 1'b0;
        while (!looped && cycles < timeout_cycles) begin
            @(negedge i_clock);
            cycles++;
            if (!i_clock_en && o_mem_r_en) begin
                $display("[ERROR] %0t o_mem_r_en expected 0 got 1", $time);
                errors++;
            end
            if (o_mem_r_en) begin
                // a self branch reads the same address every second strobe
                looped = (strobes >= 2) && (o_addr == prev2);
                prev2 = prev1;
                prev1 = o_addr;
                strobes++;
            end
            if (!looped) begin
                @(posedge i_clock);
                if (stall && stall_left == 0 && ($random(seed) & 7) == 0) begin
                    stall_left = ($random(seed) & 3) + 1;
                end
                if (stall_left > 0) begin
                    i_clock_en <= 1'b0;
                    stall_left--;
                end else begin
                    i_clock_en <= 1'b1;
                end
            end
        end
        if (!looped) begin
            $display("timeout: program never reached its final self branch at %0t", $time);
            timeouts++;
        end
    endtask

    task automatic check_state(input string tag, input logic [7:0] exp_a, exp_x, exp_y,
                               input logic [3:0] exp_flags, input logic [15:0] exp_pc);
        if (o_a !== exp_a) begin
            $display("[ERROR] %0t %s o_a expected %h got %h", $time, tag, exp_a, o_a);
            errors++;
        end
        if (o_x !== exp_x) begin
            $display("[ERROR] %0t %s o_x expected %h got %h", $time, tag, exp_x, o_x);
            errors++;
        end
        if (o_y !== exp_y) begin
            $display("[ERROR] %0t %s o_y expected %h got %h", $time, tag, exp_y, o_y);
            errors++;
        end
        if (o_flags !== exp_flags) begin
            $display("[ERROR] %0t %s o_flags expected %b got %b", $time, tag, exp_flags, o_flags);
            errors++;
        end
        if (o_pc !== exp_pc) begin
            $display("[ERROR] %0t %s o_pc expected %h got %h", $time, tag, exp_pc, o_pc);
            errors++;
        end
    endtask

    task automatic run_code(input string tag, input logic [127:0] code, input int count,
                            input logic [7:0] exp_a, exp_x, exp_y, input logic [3:0] exp_flags);
        load_code(code, count);
        apply_reset();
        run_to_loop(1'b0);
        check_state(tag, exp_a, exp_x, exp_y, exp_flags, end_addr);
    endtask

    // N V Z C after a plain register write with V and C at reset
    function automatic logic [3:0] nz_flags(input logic [7:0] val);
        return {val[7], 1'b0, val == 8'h00, 1'b0};
    endfunction

    function automatic logic [7:0] arith_opcode(input int op);
        case (op)
            0: return 8'h69;
            1: return 8'hE9;
            2: return 8'h29;
            3: return 8'h09;
            default: return 8'h49;
        endcase
    endfunction

    // integer arithmetic model with V taken from the signed range
    task automatic predict_alu(input int op, input logic [7:0] a, m, input logic c_in,
                               output logic [7:0] res, output logic n, v, z, c);
        int ua;
        int sa;
        ua = 0;
        sa = 0;
        v = 1'b0;
        c = c_in;
        case (op)
            0: begin
                ua = int'(a) + int'(m) + int'(c_in);
                sa = int'($signed(a)) + int'($signed(m)) + int'(c_in);
                c = (ua > 255);
            end
            1: begin
                // borrow is the inverted carry
                ua = int'(a) - int'(m) - (1 - int'(c_in));
                sa = int'($signed(a)) - int'($signed(m)) - (1 - int'(c_in));
                c = (ua >= 0);
            end
            2: ua = int'(a & m);
            3: ua = int'(a | m);
            default: ua = int'(a ^ m);
        endcase
        if (op < 2) begin
            v = (sa > 127) || (sa < -128);
        end
        res = ua[7:0];
        n = res[7];
        z = (res == 8'h00);
    endtask

    task automatic run_arith(input int k, input bit stall);
        logic [7:0] res;
        logic n, v, z, c;
        logic [15:0] clear_end;
        load_ptr = `CPU_RESET_PC;
        emit(seq_c[k] ? op_sec : op_clc);
        emit(op_lda);
        emit(seq_a[k]);
        emit(arith_opcode(seq_op[k]));
        emit(seq_m[k]);
        // carry out picks one of two end loops
        emit(op_bcs);
        emit(8'h03);
        emit_end();
        clear_end = end_addr;
        emit_end();
        predict_alu(seq_op[k], seq_a[k], seq_m[k], seq_c[k], res, n, v, z, c);
        apply_reset();
        run_to_loop(stall);
        check_state(stall ? "stall" : "arith", res, 8'h00, 8'h00, {n, v, z, 1'b0},
                    c ? end_addr : clear_end);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests

    task automatic reset_test();
        // registers and V left nonzero for the reset to clear
        run_code("before reset", 128'hA97F_6901_AAA8, 6, 8'h80, 8'h80, 8'h80, 4'b1100);
        load_code(128'hEA, 1);
        apply_reset();
        @(negedge i_clock);
        check_state("reset", 8'h00, 8'h00, 8'h00, 4'b0000, `CPU_RESET_PC);
        if (o_mem_r_en !== 1'b1) begin
            $display("[ERROR] %0t reset o_mem_r_en expected 1 got %b", $time, o_mem_r_en);
            errors++;
        end
        if (o_addr !== `CPU_RESET_PC) begin
            $display("[ERROR] %0t reset o_addr expected %h got %h", $time, `CPU_RESET_PC, o_addr);
            errors++;
        end
        run_to_loop(1'b0);
        check_state("nop", 8'h00, 8'h00, 8'h00, 4'b0000, end_addr);
    endtask

    task automatic loads_test();
        int k;
        int rnd;
        logic [7:0] val;
        run_code("loads", 128'hA280_A07F_A900, 6, 8'h00, 8'h80, 8'h7F, 4'b0010);
        run_code("tax tay", 128'hA9C3_AAA9_00A8, 6, 8'h00, 8'hC3, 8'h00, 4'b0010);
        run_code("tya txa", 128'hA285_A000_988A, 6, 8'h85, 8'h85, 8'h00, 4'b1000);
        run_code("tax neg", 128'hA9FF_AAA8_A901, 6, 8'h01, 8'hFF, 8'hFF, 4'b0000);
        for (k = 0; k < 4; k++) begin
            rnd = $random(seed);
            val = rnd[7:0];
            run_code("ldy tya tax", {96'h0, 8'hA0, val, 8'h98, 8'hAA}, 4,
                     val, val, val, nz_flags(val));
        end
    endtask

    task automatic arith_test();
        int k;
        int rnd;
        for (k = 0; k < 20; k++) begin
            rnd = $random(seed);
            seq_a[k] = rnd[7:0];
            seq_m[k] = rnd[15:8];
            seq_c[k] = rnd[16];
            seq_op[k] = k % 5;
            run_arith(k, 1'b0);
        end
    endtask

    task automatic incdec_test();
        run_code("inx wrap", 128'hA2FF_E8, 3, 8'h00, 8'h00, 8'h00, 4'b0010);
        run_code("dex wrap", 128'hA200_CA, 3, 8'h00, 8'hFF, 8'h00, 4'b1000);
        run_code("iny wrap", 128'hA0FF_C8C8, 4, 8'h00, 8'h00, 8'h01, 4'b0000);
        run_code("dey wrap", 128'hA000_8888, 4, 8'h00, 8'h00, 8'hFE, 4'b1000);
        run_code("inx dey sign", 128'hA27F_E8A0_8088, 6, 8'h00, 8'h80, 8'h7F, 4'b0000);
        run_code("dey zero", 128'hA001_88, 3, 8'h00, 8'h00, 8'h00, 4'b0010);
    endtask

    task automatic branch_test();
        run_code("beq taken", 128'hA900_F002_A955_A211, 8, 8'h00, 8'h11, 8'h00, 4'b0000);
        run_code("beq not taken", 128'hA901_F002_A955, 6, 8'h55, 8'h00, 8'h00, 4'b0000);
        run_code("bne taken", 128'hA901_D002_A966_A022, 8, 8'h01, 8'h00, 8'h22, 4'b0000);
        run_code("bcs taken", 128'h38_B002_A977_A233, 7, 8'h00, 8'h33, 8'h00, 4'b0000);
        run_code("bcs not taken", 128'h18_B002_A912, 5, 8'h12, 8'h00, 8'h00, 4'b0000);
        run_code("bcc taken", 128'h18_9002_A934_A056, 7, 8'h00, 8'h00, 8'h56, 4'b0000);
        run_code("bcc not taken", 128'h38_9002_A944, 5, 8'h44, 8'h00, 8'h00, 4'b0000);
        // three passes through INY DEX with BNE back by four
        run_code("bne backward", 128'hA203_A000_C8CA_D0FC, 8, 8'h00, 8'h00, 8'h03, 4'b0010);
        run_code("unknown op", 128'hA95A_02FF_EA, 5, 8'h5A, 8'h00, 8'h00, 4'b0000);
    endtask

    task automatic stall_test();
        int k;
        for (k = 0; k < 20; k++) begin
            run_arith(k, 1'b1);
        end
    endtask

    initial begin
        i_rst_n = 1'b0;
        i_clock_en = 1'b0;
        fill_memory();
        reset_test();
        loads_test();
        arith_test();
        incdec_test();
        branch_test();
        stall_test();
        @(negedge i_clock);
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : cpu_core_tb

//--- source/cpu_core.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu_core (
    input  logic                    i_clock,
    input  logic                    i_rst_n,
    input  logic                    i_clock_en,
    input  logic [`CPU_DATA_W-1:0]  i_r_data,
    output logic [`CPU_ADDR_W-1:0]  o_addr,
    output logic                    o_mem_r_en,

    // debug
    output logic [`CPU_ADDR_W-1:0]  o_pc,
    output logic [`CPU_DATA_W-1:0]  o_a,
    output logic [`CPU_DATA_W-1:0]  o_x,
    output logic [`CPU_DATA_W-1:0]  o_y,
    // N V Z C
    output logic [3:0]              o_flags
);

    logic              commit, z_flag, c_flag;
    cpu_pkg::alu_op_t  alu_op;
    cpu_pkg::reg_sel_t src, dst;
    cpu_pkg::flag_op_t flag_op;

    cpu_control u_control (
        .i_clock    (i_clock),
        .i_rst_n    (i_rst_n),
        .i_clock_en (i_clock_en),
        .i_r_data   (i_r_data),
        .i_z_flag   (z_flag),
        .i_c_flag   (c_flag),
        .o_addr     (o_addr),
        .o_mem_r_en (o_mem_r_en),
        .o_pc       (o_pc),
        .o_commit   (commit),
        .o_alu_op   (alu_op),
        .o_src      (src),
        .o_dst      (dst),
        .o_flag_op  (flag_op)
    );

    // operand byte comes straight off the read bus
    cpu_datapath u_datapath (
        .i_clock   (i_clock),
        .i_rst_n   (i_rst_n),
        .i_commit  (commit),
        .i_alu_op  (alu_op),
        .i_src     (src),
        .i_dst     (dst),
        .i_flag_op (flag_op),
        .i_operand (i_r_data),
        .o_a       (o_a),
        .o_x       (o_x),
        .o_y       (o_y),
        .o_flags   (o_flags),
        .o_z_flag  (z_flag),
        .o_c_flag  (c_flag)
    );

endmodule : cpu_core

//--- source/cpu_datapath.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu_datapath (
    input  logic                    i_clock,
    input  logic                    i_rst_n,
    input  logic                    i_commit,
    input  cpu_pkg::alu_op_t        i_alu_op,
    input  cpu_pkg::reg_sel_t       i_src,
    input  cpu_pkg::reg_sel_t       i_dst,
    input  cpu_pkg::flag_op_t       i_flag_op,
    input  logic [`CPU_DATA_W-1:0]  i_operand,
    output logic [`CPU_DATA_W-1:0]  o_a,
    output logic [`CPU_DATA_W-1:0]  o_x,
    output logic [`CPU_DATA_W-1:0]  o_y,
    output logic [3:0]              o_flags,
    output logic                    o_z_flag,
    output logic                    o_c_flag
);

    logic [`CPU_DATA_W-1:0] a_q, x_q, y_q, alu_src1, alu_out;
    logic n_q, v_q, z_q, c_q;
    logic alu_c, alu_v, alu_z, alu_n;

    // operand stands in for the source on loads
    always_comb begin
        case (i_src)
            cpu_pkg::REG_A: alu_src1 = a_q;
            cpu_pkg::REG_X: alu_src1 = x_q;
            cpu_pkg::REG_Y: alu_src1 = y_q;
            default: alu_src1 = i_operand;
        endcase
    end

    cpu_alu u_alu (
        .i_op    (i_alu_op),
        .i_src1  (alu_src1),
        .i_src2  (i_operand),
        .i_c_in  (c_q),
        .o_out   (alu_out),
        .o_c_out (alu_c),
        .o_v_out (alu_v),
        .o_z_out (alu_z),
        .o_n_out (alu_n)
    );

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            a_q <= `CPU_RESET_REG;
            x_q <= `CPU_RESET_REG;
            y_q <= `CPU_RESET_REG;
            {n_q, v_q, z_q, c_q} <= `CPU_RESET_FLAGS;
        end else if (i_commit) begin
            case (i_dst)
                cpu_pkg::REG_A: a_q <= alu_out;
                cpu_pkg::REG_X: x_q <= alu_out;
                cpu_pkg::REG_Y: y_q <= alu_out;
                default: ;
            endcase
            case (i_flag_op)
                cpu_pkg::FLAG_NZ: {n_q, z_q} <= {alu_n, alu_z};
                cpu_pkg::FLAG_NVZC: {n_q, v_q, z_q, c_q} <= {alu_n, alu_v, alu_z, alu_c};
                cpu_pkg::FLAG_SET_C: c_q <= 1'b1;
                cpu_pkg::FLAG_CLR_C: c_q <= 1'b0;
                default: ;
            endcase
        end
    end

    assign o_a = a_q;
    assign o_x = x_q;
    assign o_y = y_q;
    assign o_flags = {n_q, v_q, z_q, c_q};
    assign o_z_flag = z_q;
    assign o_c_flag = c_q;

    // NOP and unknown opcodes still commit, but must leave state alone
    a_nop_commit: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        (i_commit && i_dst == cpu_pkg::REG_NONE && i_flag_op == cpu_pkg::FLAG_NONE)
        |=> ($stable(a_q) && $stable(x_q) && $stable(y_q) && $stable(o_flags)));

endmodule : cpu_datapath

//--- source/cpu_control.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu_control (
    input  logic                    i_clock,
    input  logic                    i_rst_n,
    input  logic                    i_clock_en,
    input  logic [`CPU_DATA_W-1:0]  i_r_data,
    input  logic                    i_z_flag,
    input  logic                    i_c_flag,
    output logic [`CPU_ADDR_W-1:0]  o_addr,
    output logic                    o_mem_r_en,
    output logic [`CPU_ADDR_W-1:0]  o_pc,
    output logic                    o_commit,
    output cpu_pkg::alu_op_t        o_alu_op,
    output cpu_pkg::reg_sel_t       o_src,
    output cpu_pkg::reg_sel_t       o_dst,
    output cpu_pkg::flag_op_t       o_flag_op
);

    cpu_pkg::cpu_state_t    state_q, state_d;
    logic [`CPU_ADDR_W-1:0] pc_q, pc_d, addr_q, br_target;
    logic [`CPU_DATA_W-1:0] opcode_q;
    cpu_pkg::opcode_t       dec_opcode;
    cpu_pkg::instr_kind_t   kind;
    cpu_pkg::branch_cond_t  br_cond;
    logic                   br_inv, br_taken, commit_req, read_req;

    ////////////////////////////////////////////////////////////////////////////
    // decode

    // opcode byte arrives on the bus during DECODE, held afterwards
    assign dec_opcode = cpu_pkg::opcode_t'((state_q == cpu_pkg::STATE_DECODE) ?
                                           i_r_data : opcode_q);

    cpu_decode u_decode (
        .i_opcode      (dec_opcode),
        .o_kind        (kind),
        .o_alu_op      (o_alu_op),
        .o_src         (o_src),
        .o_dst         (o_dst),
        .o_flag_op     (o_flag_op),
        .o_branch_cond (br_cond),
        .o_branch_inv  (br_inv)
    );

    assign br_taken = br_inv ^ ((br_cond == cpu_pkg::BR_C) ? i_c_flag : i_z_flag);
    // PC already points past the offset byte
    assign br_target = pc_q + {{`CPU_OFFSET_EXT{i_r_data[`CPU_DATA_W-1]}}, i_r_data};

    ////////////////////////////////////////////////////////////////////////////
    // sequencer

    always_comb begin
        state_d = state_q;
        pc_d = pc_q;
        commit_req = 1'b0;
        read_req = 1'b0;
        case (state_q)
            cpu_pkg::STATE_FETCH: begin
                read_req = 1'b1;
                pc_d = pc_q + `CPU_PC_STEP;
                state_d = cpu_pkg::STATE_DECODE;
            end
            cpu_pkg::STATE_DECODE: begin
                if (kind == cpu_pkg::KIND_IMPLIED) begin
                    commit_req = 1'b1;
                    state_d = cpu_pkg::STATE_FETCH;
                end else begin
                    read_req = 1'b1;
                    pc_d = pc_q + `CPU_PC_STEP;
                    state_d = cpu_pkg::STATE_EXEC;
                end
            end
            cpu_pkg::STATE_EXEC: begin
                commit_req = (kind == cpu_pkg::KIND_IMMEDIATE);
                if (kind == cpu_pkg::KIND_BRANCH && br_taken) begin
                    pc_d = br_target;
                end
                state_d = cpu_pkg::STATE_FETCH;
            end
            default: state_d = cpu_pkg::STATE_FETCH;
        endcase
    end

    assign o_commit = i_clock_en & commit_req;
    assign o_mem_r_en = i_clock_en & read_req;
    // address passes through on a read, then stays latched
    assign o_addr = o_mem_r_en ? pc_q : addr_q;
    assign o_pc = pc_q;

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            state_q <= cpu_pkg::STATE_FETCH;
            pc_q <= `CPU_RESET_PC;
            addr_q <= `CPU_RESET_PC;
        end else if (i_clock_en) begin
            state_q <= state_d;
            pc_q <= pc_d;
            if (o_mem_r_en) begin
                addr_q <= pc_q;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_clock_en && state_q == cpu_pkg::STATE_DECODE) begin
            opcode_q <= i_r_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks

    a_stall_quiet: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        !i_clock_en |-> !o_commit && !o_mem_r_en);

    a_state_legal: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        state_q inside {cpu_pkg::STATE_FETCH, cpu_pkg::STATE_DECODE, cpu_pkg::STATE_EXEC});

endmodule : cpu_control

//--- source/cpu_decode.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu_decode (
    input  cpu_pkg::opcode_t      i_opcode,
    output cpu_pkg::instr_kind_t  o_kind,
    output cpu_pkg::alu_op_t      o_alu_op,
    output cpu_pkg::reg_sel_t     o_src,
    output cpu_pkg::reg_sel_t     o_dst,
    output cpu_pkg::flag_op_t     o_flag_op,
    output cpu_pkg::branch_cond_t o_branch_cond,
    output logic                  o_branch_inv
);

    // one case per control field, unknown opcodes fall to the defaults
    always_comb begin
        case (i_opcode)
            cpu_pkg::OP_LDA_IMM, cpu_pkg::OP_LDX_IMM, cpu_pkg::OP_LDY_IMM,
            cpu_pkg::OP_ADC_IMM, cpu_pkg::OP_SBC_IMM, cpu_pkg::OP_AND_IMM,
            cpu_pkg::OP_ORA_IMM, cpu_pkg::OP_EOR_IMM: o_kind = cpu_pkg::KIND_IMMEDIATE;
            cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE,
            cpu_pkg::OP_BCS, cpu_pkg::OP_BCC: o_kind = cpu_pkg::KIND_BRANCH;
            default: o_kind = cpu_pkg::KIND_IMPLIED;
        endcase

        case (i_opcode)
            cpu_pkg::OP_ADC_IMM: o_alu_op = cpu_pkg::ALU_ADC;
            cpu_pkg::OP_SBC_IMM: o_alu_op = cpu_pkg::ALU_SBC;
            cpu_pkg::OP_AND_IMM: o_alu_op = cpu_pkg::ALU_AND;
            cpu_pkg::OP_ORA_IMM: o_alu_op = cpu_pkg::ALU_ORA;
            cpu_pkg::OP_EOR_IMM: o_alu_op = cpu_pkg::ALU_EOR;
            cpu_pkg::OP_INX, cpu_pkg::OP_INY: o_alu_op = cpu_pkg::ALU_INC;
            cpu_pkg::OP_DEX, cpu_pkg::OP_DEY: o_alu_op = cpu_pkg::ALU_DEC;
            default: o_alu_op = cpu_pkg::ALU_PASS;
        endcase

        // first ALU input
        case (i_opcode)
            cpu_pkg::OP_ADC_IMM, cpu_pkg::OP_SBC_IMM, cpu_pkg::OP_AND_IMM,
            cpu_pkg::OP_ORA_IMM, cpu_pkg::OP_EOR_IMM,
            cpu_pkg::OP_TAX, cpu_pkg::OP_TAY: o_src = cpu_pkg::REG_A;
            cpu_pkg::OP_TXA, cpu_pkg::OP_INX, cpu_pkg::OP_DEX: o_src = cpu_pkg::REG_X;
            cpu_pkg::OP_TYA, cpu_pkg::OP_INY, cpu_pkg::OP_DEY: o_src = cpu_pkg::REG_Y;
            cpu_pkg::OP_LDA_IMM, cpu_pkg::OP_LDX_IMM,
            cpu_pkg::OP_LDY_IMM: o_src = cpu_pkg::REG_OPERAND;
            default: o_src = cpu_pkg::REG_NONE;
        endcase

        case (i_opcode)
            cpu_pkg::OP_LDA_IMM, cpu_pkg::OP_ADC_IMM, cpu_pkg::OP_SBC_IMM,
            cpu_pkg::OP_AND_IMM, cpu_pkg::OP_ORA_IMM, cpu_pkg::OP_EOR_IMM,
            cpu_pkg::OP_TXA, cpu_pkg::OP_TYA: o_dst = cpu_pkg::REG_A;
            cpu_pkg::OP_LDX_IMM, cpu_pkg::OP_TAX,
            cpu_pkg::OP_INX, cpu_pkg::OP_DEX: o_dst = cpu_pkg::REG_X;
            cpu_pkg::OP_LDY_IMM, cpu_pkg::OP_TAY,
            cpu_pkg::OP_INY, cpu_pkg::OP_DEY: o_dst = cpu_pkg::REG_Y;
            default: o_dst = cpu_pkg::REG_NONE;
        endcase

        // every register write also sets N and Z
        if (i_opcode == cpu_pkg::OP_ADC_IMM || i_opcode == cpu_pkg::OP_SBC_IMM) begin
            o_flag_op = cpu_pkg::FLAG_NVZC;
        end else if (i_opcode == cpu_pkg::OP_CLC) begin
            o_flag_op = cpu_pkg::FLAG_CLR_C;
        end else if (i_opcode == cpu_pkg::OP_SEC) begin
            o_flag_op = cpu_pkg::FLAG_SET_C;
        end else if (o_dst != cpu_pkg::REG_NONE) begin
            o_flag_op = cpu_pkg::FLAG_NZ;
        end else begin
            o_flag_op = cpu_pkg::FLAG_NONE;
        end

        // branch taken when flag xor invert is high
        o_branch_cond = (i_opcode == cpu_pkg::OP_BCS || i_opcode == cpu_pkg::OP_BCC) ?
                        cpu_pkg::BR_C : cpu_pkg::BR_Z;
        o_branch_inv = (i_opcode == cpu_pkg::OP_BNE || i_opcode == cpu_pkg::OP_BCC);
    end

endmodule : cpu_decode

//--- source/cpu_alu.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu_alu (
    input  cpu_pkg::alu_op_t        i_op,
    input  logic [`CPU_DATA_W-1:0]  i_src1,
    input  logic [`CPU_DATA_W-1:0]  i_src2,
    input  logic                    i_c_in,
    output logic [`CPU_DATA_W-1:0]  o_out,
    output logic                    o_c_out,
    output logic                    o_v_out,
    output logic                    o_z_out,
    output logic                    o_n_out
);

    logic [`CPU_DATA_W-1:0] m;
    logic [`CPU_DATA_W:0]   sum;

    // SBC is ADC with the memory operand inverted
    assign m = (i_op == cpu_pkg::ALU_SBC) ? ~i_src2 : i_src2;
    assign sum = {1'b0, i_src1} + {1'b0, m} + {{`CPU_DATA_W{1'b0}}, i_c_in};

    always_comb begin
        o_out = i_src1;
        o_c_out = i_c_in;
        o_v_out = 1'b0;
        case (i_op)
            cpu_pkg::ALU_PASS: o_out = i_src1;
            cpu_pkg::ALU_ADC,
            cpu_pkg::ALU_SBC: begin
                o_out = sum[`CPU_DATA_W-1:0];
                o_c_out = sum[`CPU_DATA_W];
                // same input signs, result sign differs
                o_v_out = (i_src1[`CPU_DATA_W-1] == m[`CPU_DATA_W-1]) &&
                          (sum[`CPU_DATA_W-1] != i_src1[`CPU_DATA_W-1]);
            end
            cpu_pkg::ALU_AND: o_out = i_src1 & i_src2;
            cpu_pkg::ALU_ORA: o_out = i_src1 | i_src2;
            cpu_pkg::ALU_EOR: o_out = i_src1 ^ i_src2;
            // wraps modulo 256
            cpu_pkg::ALU_INC: o_out = i_src1 + `CPU_DATA_ONE;
            cpu_pkg::ALU_DEC: o_out = i_src1 - `CPU_DATA_ONE;
            default: o_out = i_src1;
        endcase
    end

    assign o_n_out = o_out[`CPU_DATA_W-1];
    assign o_z_out = (o_out == '0);

endmodule : cpu_alu

//--- source/cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

    typedef enum logic [1:0] {
        STATE_FETCH  = 2'd0,
        STATE_DECODE = 2'd1,
        STATE_EXEC   = 2'd2
    } cpu_state_t;

    // standard 6502 encodings, immediate and implied forms only
    typedef enum logic [`CPU_DATA_W-1:0] {
        OP_LDA_IMM = 8'hA9,
        OP_LDX_IMM = 8'hA2,
        OP_LDY_IMM = 8'hA0,
        OP_ADC_IMM = 8'h69,
        OP_SBC_IMM = 8'hE9,
        OP_AND_IMM = 8'h29,
        OP_ORA_IMM = 8'h09,
        OP_EOR_IMM = 8'h49,
        OP_TAX     = 8'hAA,
        OP_TAY     = 8'hA8,
        OP_TXA     = 8'h8A,
        OP_TYA     = 8'h98,
        OP_INX     = 8'hE8,
        OP_DEX     = 8'hCA,
        OP_INY     = 8'hC8,
        OP_DEY     = 8'h88,
        OP_CLC     = 8'h18,
        OP_SEC     = 8'h38,
        OP_NOP     = 8'hEA,
        OP_BEQ     = 8'hF0,
        OP_BNE     = 8'hD0,
        OP_BCS     = 8'hB0,
        OP_BCC     = 8'h90
    } opcode_t;

    typedef enum logic [1:0] {KIND_IMPLIED, KIND_IMMEDIATE, KIND_BRANCH} instr_kind_t;

    typedef enum logic [2:0] {
        ALU_PASS, ALU_ADC, ALU_SBC, ALU_AND, ALU_ORA, ALU_EOR, ALU_INC, ALU_DEC
    } alu_op_t;

    typedef enum logic [2:0] {REG_A, REG_X, REG_Y, REG_OPERAND, REG_NONE} reg_sel_t;

    typedef enum logic [2:0] {FLAG_NONE, FLAG_NZ, FLAG_NVZC, FLAG_SET_C, FLAG_CLR_C} flag_op_t;

    typedef enum logic [1:0] {BR_Z, BR_C} branch_cond_t;

endpackage : cpu_pkg

//--- source/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// widths fixed by the instruction set
`define CPU_DATA_W 8
`define CPU_ADDR_W 16

// architectural state after reset
`define CPU_RESET_PC 16'hC000
`define CPU_RESET_REG 8'h00
// N V Z C
`define CPU_RESET_FLAGS 4'b0000

// unit steps for the PC and for INC/DEC
`define CPU_PC_STEP 16'h0001
`define CPU_DATA_ONE 8'h01

// bits added when a branch offset is sign extended to an address
`define CPU_OFFSET_EXT (`CPU_ADDR_W - `CPU_DATA_W)

`endif
